// ==== frontend_pkg.sv ====
// Front end package with widths, vector types, fetch structs and enums
`default_nettype none

package frontend_pkg;

  // Datapath widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Global history length of the gshare predictor
  localparam int HLEN = 4;

  // Index bits shared by the BTB and the counter table
  localparam int BTB_BITS = 4;

  // Tag covers the pc bits above the index and the byte offset
  localparam int BTB_TAG_LEN = XLEN - BTB_BITS - 2;

  // Cache requests allowed in flight
  localparam int MAX_OUTSTANDING = 2;

  // Pointer and occupancy widths of the outstanding-request queue
  localparam int QPTR_BITS = $clog2(MAX_OUTSTANDING);
  localparam int QCNT_BITS = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [ILEN-1:0]        inst_t;
  typedef logic [BTB_BITS-1:0]    btb_idx_t;
  typedef logic [BTB_TAG_LEN-1:0] btb_tag_t;
  typedef logic [HLEN-1:0]        ghist_t;

  // Reset fetch address
  localparam xlen_t BOOT_PC = '0;

  // Exception codes carried to decode
  typedef enum logic [3:0] {
    EXC_NONE               = 4'h0,
    EXC_INSTR_ACCESS_FAULT = 4'h1
  } except_code_t;

  // Prediction attached to every fetched pc, 65 bits
  typedef struct packed {
    xlen_t pc;
    xlen_t target;
    logic  taken;
  } prediction_t;

  // Branch outcome from the branch unit, one-cycle pulse
  typedef struct packed {
    logic  valid;
    logic  mispredict;
    logic  taken;
    xlen_t pc;
    xlen_t target;
  } resolution_t;

  // Cache response payload
  typedef struct packed {
    xlen_t pc;
    inst_t instruction;
    logic  access_fault;
  } icache_out_t;

  // Payload handed to decode
  typedef struct packed {
    inst_t        instruction;
    prediction_t  pred;
    except_code_t except_code;
  } issue_t;

  // Request controller states
  typedef enum logic {
    F_IDLE,
    F_FETCH
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== btb.sv ====
// Branch target buffer, direct mapped, trained by taken branch resolutions
`timescale 1ns/1ps
`default_nettype none

module btb import frontend_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  // Lookup side, driven by the fetch pc
  input  wire xlen_t      lookup_pc_i,
  output logic            hit_o,
  output xlen_t           target_o,
  // Update side from the branch unit
  input  var resolution_t res_i
);

  // Entry storage
  logic [2**BTB_BITS-1:0] valid_q;
  btb_tag_t               tag_q    [2**BTB_BITS];
  xlen_t                  target_q [2**BTB_BITS];

  // Split of the lookup and update addresses
  btb_idx_t lookup_idx;
  btb_tag_t lookup_tag;
  btb_idx_t upd_idx;
  btb_tag_t upd_tag;
  logic     upd_en;

  // Bits 1:0 are the byte offset of an aligned word
  assign lookup_idx = lookup_pc_i[BTB_BITS+1:2];
  assign lookup_tag = lookup_pc_i[XLEN-1:BTB_BITS+2];
  assign upd_idx    = res_i.pc[BTB_BITS+1:2];
  assign upd_tag    = res_i.pc[XLEN-1:BTB_BITS+2];

  // Only taken branches allocate or refresh an entry
  assign upd_en = res_i.valid & res_i.taken;

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Tag and target arrays
  always_ff @(posedge clk_i) begin
    if (upd_en) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= res_i.target;
    end
  end

  // Hit needs a live entry with a matching tag
  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o = target_q[lookup_idx];

endmodule

`default_nettype wire

// ==== gshare_bpu.sv ====
// Gshare direction predictor with global history and two-bit counters
`timescale 1ns/1ps
`default_nettype none

module gshare_bpu import frontend_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  // Lookup side
  input  wire xlen_t      lookup_pc_i,
  output logic            taken_o,
  // Training from the branch unit
  input  var resolution_t res_i
);

  // Counter table and global history
  logic [1:0] cnt_q [2**BTB_BITS];
  ghist_t     ghist_q;

  btb_idx_t lookup_idx;
  btb_idx_t upd_idx;
  logic [1:0] upd_cnt;

  // Pc index bits hashed with the history
  assign lookup_idx = lookup_pc_i[BTB_BITS+1:2] ^ btb_idx_t'(ghist_q);
  assign upd_idx    = res_i.pc[BTB_BITS+1:2] ^ btb_idx_t'(ghist_q);

  // Counter high bit is the direction
  assign taken_o = cnt_q[lookup_idx][1];

  // Saturating step of the selected counter
  always_comb begin
    upd_cnt = cnt_q[upd_idx];
    if (res_i.taken && (cnt_q[upd_idx] != 2'b11)) begin
      upd_cnt = cnt_q[upd_idx] + 2'b01;
    end else if (!res_i.taken && (cnt_q[upd_idx] != 2'b00)) begin
      upd_cnt = cnt_q[upd_idx] - 2'b01;
    end
  end

  // Counters start weakly not-taken, history starts empty
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**BTB_BITS; i++) begin
        cnt_q[i] <= 2'b01;
      end
      ghist_q <= '0;
    end else if (res_i.valid) begin
      cnt_q[upd_idx] <= upd_cnt;
      // Newest outcome enters at bit 0
      ghist_q <= {ghist_q[HLEN-2:0], res_i.taken};
    end
  end

endmodule

`default_nettype wire

// ==== pc_gen_stage.sv ====
// PC generator, picks the next fetch address by redirect priority
`timescale 1ns/1ps
`default_nettype none

module pc_gen_stage import frontend_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  // Exception redirect from the back end
  input  wire             except_i,
  input  wire xlen_t      except_pc_i,
  // Branch unit outcome
  input  var resolution_t res_i,
  // Prediction and request handshake from fetch
  input  var prediction_t pred_i,
  input  wire             fetch_ready_i,
  output xlen_t           pc_o
);

  xlen_t pc_q;
  xlen_t pc_d;

  // Exception first, then misprediction, then the accepted fetch
  always_comb begin
    pc_d = pc_q;
    if (except_i) begin
      pc_d = except_pc_i;
    end else if (res_i.valid && res_i.mispredict) begin
      // Resume on the resolved path
      pc_d = res_i.taken ? res_i.target : res_i.pc + xlen_t'(4);
    end else if (fetch_ready_i) begin
      // Follow the predictor on taken, else the next word
      pc_d = pred_i.taken ? pred_i.target : pc_q + xlen_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// Fetch stage issuing cache requests and pairing responses with predictions
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import frontend_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  input  wire             flush_i,
  // PC generator side
  input  wire xlen_t      pc_i,
  output logic            fetch_ready_o,
  // Cache request channel
  output xlen_t           addr_o,
  output logic            addr_valid_o,
  input  wire             addr_ready_i,
  // Cache response channel
  input  var icache_out_t data_i,
  input  wire             data_valid_i,
  output logic            data_ready_o,
  // Decode channel
  output issue_t          issue_o,
  output logic            issue_valid_o,
  input  wire             issue_ready_i,
  // Prediction for the current pc
  output prediction_t     pred_o,
  input  var resolution_t res_i
);

  fetch_state_t state_q;

  // Predictor outputs
  logic  btb_hit;
  xlen_t btb_target;
  logic  bpu_taken;

  // Outstanding-request queue, payload has no reset
  prediction_t          q_pred  [MAX_OUTSTANDING];
  logic                 q_epoch [MAX_OUTSTANDING];
  logic [QPTR_BITS-1:0] wr_ptr_q;
  logic [QPTR_BITS-1:0] rd_ptr_q;
  logic [QCNT_BITS-1:0] cnt_q;

  // Flips on every flush to mark older requests stale
  logic epoch_q;

  logic req_acc;
  logic rsp_acc;
  logic rsp_live;

  btb u_btb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target),
    .res_i       (res_i)
  );

  gshare_bpu u_gshare_bpu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc_i),
    .taken_o     (bpu_taken),
    .res_i       (res_i)
  );

  // Taken only when the BTB knows a target
  assign pred_o.pc     = pc_i;
  assign pred_o.target = btb_target;
  assign pred_o.taken  = btb_hit & bpu_taken;

  // Idle for one cycle out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= F_IDLE;
    end else begin
      state_q <= F_FETCH;
    end
  end

  // Request while the queue has room
  assign addr_o        = pc_i;
  assign addr_valid_o  = (state_q == F_FETCH) && (cnt_q < QCNT_BITS'(MAX_OUTSTANDING));
  assign req_acc       = addr_valid_o & addr_ready_i;
  assign fetch_ready_o = req_acc;

  // Accept a response only if the output register can take it
  assign data_ready_o = (cnt_q != '0) && (!issue_valid_o || issue_ready_i);
  assign rsp_acc      = data_valid_i & data_ready_o;
  // A stale epoch or a same-cycle flush drops the response
  assign rsp_live     = rsp_acc && (q_epoch[rd_ptr_q] == epoch_q) && !flush_i;

  // Queue control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      epoch_q  <= 1'b0;
    end else begin
      if (req_acc) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rsp_acc) rd_ptr_q <= rd_ptr_q + 1'b1;
      // In-flight requests stay counted across a flush
      cnt_q <= cnt_q + QCNT_BITS'(req_acc) - QCNT_BITS'(rsp_acc);
      if (flush_i) epoch_q <= ~epoch_q;
    end
  end

  // Queue payload, tagged with the epoch at issue time
  always_ff @(posedge clk_i) begin
    if (req_acc) begin
      q_pred[wr_ptr_q]  <= pred_o;
      q_epoch[wr_ptr_q] <= epoch_q;
    end
  end

  // Output register valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_valid_o <= 1'b0;
    end else if (flush_i) begin
      issue_valid_o <= 1'b0;
    end else if (rsp_live) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Output register payload
  always_ff @(posedge clk_i) begin
    if (rsp_live) begin
      issue_o.instruction <= data_i.instruction;
      issue_o.pred        <= q_pred[rd_ptr_q];
      issue_o.except_code <= data_i.access_fault ? EXC_INSTR_ACCESS_FAULT : EXC_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== front_end.sv ====
// Instruction front end top joining the PC generator and the fetch stage
`timescale 1ns/1ps
`default_nettype none

module front_end import frontend_pkg::*; (
  input  wire             clk_i,
  input  wire             rst_n_i,
  input  wire             flush_i,
  // Instruction cache
  output xlen_t           addr_o,
  output logic            addr_valid_o,
  input  wire             addr_ready_i,
  input  var icache_out_t data_i,
  input  wire             data_valid_i,
  output logic            data_ready_o,
  // Decode
  output issue_t          issue_o,
  output logic            issue_valid_o,
  input  wire             issue_ready_i,
  // Branch unit
  input  var resolution_t res_i,
  // Back end redirect
  input  wire             except_i,
  input  wire xlen_t      except_pc_i
);

  // Fetch to PC generator
  prediction_t pred;
  logic        fetch_ready;
  // PC generator to fetch
  xlen_t       pc;

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .pred_o        (pred),
    .res_i         (res_i)
  );

  pc_gen_stage u_pc_gen_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res_i         (res_i),
    .pred_i        (pred),
    .fetch_ready_i (fetch_ready),
    .pc_o          (pc)
  );

endmodule

`default_nettype wire

// ==== front_end_asserts.sv ====
// Handshake and occupancy assertions for the fetch stage
`timescale 1ns/1ps
`default_nettype none

module front_end_asserts import frontend_pkg::*; (
  input wire                 clk_i,
  input wire                 rst_n_i,
  input wire                 flush_i,
  input wire xlen_t          addr_i,
  input wire                 addr_valid_i,
  input wire                 addr_ready_i,
  input wire                 data_valid_i,
  input wire                 data_ready_i,
  input var issue_t          issue_i,
  input wire                 issue_valid_i,
  input wire                 issue_ready_i
);

  // Assertion failures so far
  int fail_cnt = 0;

  // Requests in flight as seen on the cache ports
  int flight_cnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flight_cnt <= 0;
    end else begin
      flight_cnt <= flight_cnt + int'(addr_valid_i && addr_ready_i)
                    - int'(data_valid_i && data_ready_i);
    end
  end

  // Stalled request keeps valid and address until the cache takes it
  req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_i && !addr_ready_i && !flush_i |=> addr_valid_i && $stable(addr_i))
  else begin
    $error("cache request changed while stalled");
    fail_cnt++;
  end

  // Decode payload holds under back-pressure
  issue_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !issue_ready_i && !flush_i |=>
      issue_valid_i && $stable(issue_i.instruction) && $stable(issue_i.pred.pc) &&
      $stable(issue_i.pred.taken) && $stable(issue_i.except_code))
  else begin
    $error("issue payload changed under back-pressure");
    fail_cnt++;
  end

  // Control outputs stay low in reset
  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_n_i |-> !addr_valid_i && !issue_valid_i && !data_ready_i)
  else begin
    $error("valid or ready high during reset");
    fail_cnt++;
  end

  // At most two requests in flight on the cache ports
  occupancy_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flight_cnt <= MAX_OUTSTANDING)
  else begin
    $error("more cache requests in flight than allowed");
    fail_cnt++;
  end

endmodule

bind fetch_stage front_end_asserts u_front_end_asserts (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .flush_i       (flush_i),
  .addr_i        (addr_o),
  .addr_valid_i  (addr_valid_o),
  .addr_ready_i  (addr_ready_i),
  .data_valid_i  (data_valid_i),
  .data_ready_i  (data_ready_o),
  .issue_i       (issue_o),
  .issue_valid_i (issue_valid_o),
  .issue_ready_i (issue_ready_i)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source with a 10 ns period and reset low for 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
  end

  // Half period of 5 ns
  always #5 clk_o = ~clk_o;

  // Release after five rising edges
  initial begin
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_front_end.sv ====
// Testbench for the front end with cache, decode and branch unit models
`timescale 1ns/1ps
`default_nettype none

module tb_front_end import frontend_pkg::*; ();

  localparam int N_ISSUE        = 2000;
  // Ten cycles per instruction covers the slowest cache and decode mix
  localparam int TIMEOUT_CYCLES = 10 * N_ISSUE;
  // Gap between redirects lets the one-bit epoch drain
  localparam int REDIRECT_GAP   = 16;

  logic        clk;
  logic        rst_n;
  logic        flush;
  xlen_t       addr;
  logic        addr_valid;
  logic        addr_ready;
  icache_out_t data;
  logic        data_valid;
  logic        data_ready;
  issue_t      issue;
  logic        issue_valid;
  logic        issue_ready;
  resolution_t res;
  logic        except_v;
  xlen_t       except_pc;

  // Reference BTB and gshare state
  logic     ref_valid  [2**BTB_BITS];
  btb_tag_t ref_tag    [2**BTB_BITS];
  xlen_t    ref_target [2**BTB_BITS];
  logic [1:0] ref_cnt  [2**BTB_BITS];
  ghist_t   ref_hist;

  // Expected issue stream
  xlen_t exp_pc;
  xlen_t last_pc;
  int    issued;
  int    cycle;
  int    quiet;

  // Cache model queue of pending addresses and the cycle each may answer
  xlen_t cq_addr [$];
  int    cq_due  [$];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  front_end UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .flush_i       (flush),
    .addr_o        (addr),
    .addr_valid_o  (addr_valid),
    .addr_ready_i  (addr_ready),
    .data_i        (data),
    .data_valid_i  (data_valid),
    .data_ready_o  (data_ready),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready),
    .res_i         (res),
    .except_i      (except_v),
    .except_pc_i   (except_pc)
  );

  // Instruction memory contents, built from every address bit
  function automatic inst_t mem_word(input xlen_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h1357_9bdf;
  endfunction

  // Fault region 0x200 to 0x27f
  function automatic logic in_fault(input xlen_t a);
    return (a >= 32'h200) && (a < 32'h280);
  endfunction

  function automatic prediction_t ref_predict(input xlen_t pc);
    prediction_t p;
    btb_idx_t    idx;
    logic        hit;
    idx      = pc[BTB_BITS+1:2];
    hit      = ref_valid[idx] && (ref_tag[idx] == pc[XLEN-1:BTB_BITS+2]);
    p.pc     = pc;
    p.target = ref_target[idx];
    p.taken  = hit && ref_cnt[idx ^ btb_idx_t'(ref_hist)][1];
    return p;
  endfunction

  task automatic ref_train(input resolution_t r);
    btb_idx_t idx;
    btb_idx_t gi;
    idx = r.pc[BTB_BITS+1:2];
    gi  = idx ^ btb_idx_t'(ref_hist);
    if (r.taken) begin
      ref_valid[idx]  = 1'b1;
      ref_tag[idx]    = r.pc[XLEN-1:BTB_BITS+2];
      ref_target[idx] = r.target;
      if (ref_cnt[gi] != 2'b11) ref_cnt[gi] = ref_cnt[gi] + 2'b01;
    end else if (ref_cnt[gi] != 2'b00) begin
      ref_cnt[gi] = ref_cnt[gi] - 2'b01;
    end
    ref_hist = {ref_hist[HLEN-2:0], r.taken};
  endtask

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pc(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Target only counts when the prediction is taken
  task automatic check_pred(input string name, input prediction_t exp,
                            input prediction_t act);
    if ((act.pc !== exp.pc) || (act.taken !== exp.taken) ||
        (exp.taken && (act.target !== exp.target))) begin
      $display("** Error %s: expected pc %h taken %b target %h, actual pc %h taken %b target %h",
               name, exp.pc, exp.taken, exp.target, act.pc, act.taken, act.target);
      abort_run();
    end
  endtask

  task automatic check_exc(input string name, input except_code_t exp,
                           input except_code_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  initial begin
    void'($urandom(23));
    flush       = 1'b0;
    addr_ready  = 1'b0;
    data        = '0;
    data_valid  = 1'b0;
    issue_ready = 1'b0;
    res         = '0;
    except_v    = 1'b0;
    except_pc   = '0;
    for (int i = 0; i < 2**BTB_BITS; i++) begin
      ref_valid[i]  = 1'b0;
      ref_tag[i]    = '0;
      ref_target[i] = '0;
      ref_cnt[i]    = 2'b01;
    end
    ref_hist = '0;
    exp_pc   = BOOT_PC;
    last_pc  = BOOT_PC;
    issued   = 0;
    cycle    = 0;
    quiet    = 0;
  end

  always @(posedge clk) begin : model
    prediction_t p;
    resolution_t r;
    int          pick;
    if (rst_n) begin
      cycle++;
      // Any assertion failure ends the run at once
      if (UUT.u_fetch_stage.u_front_end_asserts.fail_cnt != 0) begin
        $display("An assertion in the fetch stage failed");
        abort_run();
      end
      // Decode transfer is checked before this edge's redirect takes effect
      if (issue_valid && issue_ready) begin
        p = ref_predict(exp_pc);
        check_pc("issue pc", exp_pc, issue.pred.pc);
        check_inst("issue instruction", mem_word(exp_pc), issue.instruction);
        check_exc("issue exception", in_fault(exp_pc) ? EXC_INSTR_ACCESS_FAULT : EXC_NONE,
                  issue.except_code);
        check_pred("issue prediction", p, issue.pred);
        last_pc = exp_pc;
        exp_pc  = p.taken ? p.target : exp_pc + 32'd4;
        issued++;
      end
      // Redirects driven for this cycle
      if (res.valid) begin
        ref_train(res);
        exp_pc = res.taken ? res.target : res.pc + 32'd4;
      end
      if (except_v) exp_pc = except_pc;
      // Cache responses leave in request order
      if (data_valid && data_ready) begin
        void'(cq_addr.pop_front());
        void'(cq_due.pop_front());
      end
      if (addr_valid && addr_ready) begin
        cq_addr.push_back(addr);
        cq_due.push_back(cycle + int'($urandom % 4));
      end
      if ((cq_addr.size() != 0) && (cq_due[0] <= cycle)) begin
        data_valid             <= 1'b1;
        data.pc                <= cq_addr[0];
        data.instruction       <= mem_word(cq_addr[0]);
        data.access_fault      <= in_fault(cq_addr[0]);
      end else begin
        data_valid <= 1'b0;
      end
      addr_ready  <= ($urandom % 5) != 0;
      issue_ready <= ($urandom % 4) != 0;
      // Occasional mispredict or exception raised together with flush
      res      <= '0;
      except_v <= 1'b0;
      flush    <= 1'b0;
      quiet++;
      if (quiet >= REDIRECT_GAP) begin
        pick = int'($urandom % 100);
        if (pick < 3) begin
          r.valid      = 1'b1;
          r.mispredict = 1'b1;
          r.taken      = $urandom % 2;
          r.pc         = last_pc;
          r.target     = xlen_t'(($urandom % 256) * 4);
          res   <= r;
          flush <= 1'b1;
          quiet = 0;
        end else if (pick < 4) begin
          except_v  <= 1'b1;
          except_pc <= xlen_t'(($urandom % 256) * 4);
          flush     <= 1'b1;
          quiet = 0;
        end
      end
    end
  end

  initial begin
    wait ((issued >= N_ISSUE) || (cycle >= TIMEOUT_CYCLES));
    if (issued < N_ISSUE) begin
      $display("Timeout after %0d cycles with %0d instructions issued", cycle, issued);
      $display("FAIL: see errors above");
      $fatal(1, "run did not finish in time");
    end else if (UUT.u_fetch_stage.u_front_end_asserts.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "assertion failures during the run");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
frontend_pkg.sv
btb.sv
gshare_bpu.sv
pc_gen_stage.sv
fetch_stage.sv
front_end.sv
front_end_asserts.sv
tb_clk_gen.sv
tb_front_end.sv

// ==== Bender.yml ====
package:
  name: front_end

sources:
  - frontend_pkg.sv
  - btb.sv
  - gshare_bpu.sv
  - pc_gen_stage.sv
  - fetch_stage.sv
  - front_end.sv
  - target: test
    files:
      - front_end_asserts.sv
      - tb_clk_gen.sv
      - tb_front_end.sv
